//--- common/vec_pkg.sv
// Vector coprocessor package with widths, opcodes and the structs shared by all blocks
`default_nettype none

package vec_pkg;

  ////////////////////
  // Widths
  ////////////////////

  // Fixed element width of the whole datapath
  localparam int unsigned ElemWidth = 32;
  // Architectural vector registers
  localparam int unsigned NrVRegs   = 32;

  typedef logic [4:0]           vreg_idx_t;
  typedef logic [ElemWidth-1:0] elem_t;
  // Wide enough for any configured maximum vector length
  typedef logic [15:0]          vl_t;

  ////////////////////
  // Opcodes
  ////////////////////

  typedef enum logic [2:0] {
    VSETVL,
    VADD,
    VSUB,
    VAND,
    VOR,
    VXOR,
    VMV_VX,
    VEXT_XV
  } vec_op_e;

  ////////////////////
  // Structs
  ////////////////////

  // Core request; scalar is the vl request, broadcast value or element index
  typedef struct packed {
    vec_op_e   op;
    vreg_idx_t vd;
    vreg_idx_t vs1;
    vreg_idx_t vs2;
    elem_t     scalar;
  } vec_req_t;

  // Response to the core
  typedef struct packed {
    vec_op_e op;
    elem_t   data;
  } vec_resp_t;

  // Dispatcher to sequencer, request plus the vl in force
  typedef struct packed {
    vec_req_t req;
    vl_t      vl;
  } seq_cmd_t;

  // Broadcast to every lane, one row per cycle
  typedef struct packed {
    vec_op_e   op;
    vreg_idx_t vd;
    vreg_idx_t vs1;
    vreg_idx_t vs2;
    elem_t     scalar;
    vl_t       row;
    vl_t       vl;
  } lane_cmd_t;

endpackage

`default_nettype wire

//--- hdl/vec_skid_fifo.sv
// Two-entry valid/ready buffer that decouples producer and consumer for any payload
`default_nettype none
`timescale 1ns/1ps

module vec_skid_fifo #(
  parameter type payload_t = logic
) (
  input  logic     clk_i,
  input  logic     rst_n_i,
  // Producer side
  input  payload_t data_i,
  input  logic     valid_i,
  output logic     ready_o,
  // Consumer side
  output payload_t data_o,
  output logic     valid_o,
  input  logic     ready_i
);

  payload_t   mem_q [2];
  logic       wr_ptr_q;
  logic       rd_ptr_q;
  logic [1:0] count_q;
  logic [1:0] count_d;
  // Registered ready, so the producer never sees a path through ready_i
  logic       ready_q;
  logic       push;
  logic       pop;

  assign push    = valid_i & ready_q;
  assign pop     = valid_o & ready_i;
  assign valid_o = (count_q != 2'd0);
  assign ready_o = ready_q;
  assign data_o  = mem_q[rd_ptr_q];

  always_comb begin
    case ({push, pop})
      2'b10:   count_d = count_q + 2'd1;
      2'b01:   count_d = count_q - 2'd1;
      default: count_d = count_q;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      count_q  <= 2'd0;
      wr_ptr_q <= 1'b0;
      rd_ptr_q <= 1'b0;
      ready_q  <= 1'b0;
    end else begin
      count_q <= count_d;
      ready_q <= (count_d != 2'd2);
      if (push) wr_ptr_q <= ~wr_ptr_q;
      if (pop)  rd_ptr_q <= ~rd_ptr_q;
    end
  end

  // Storage
  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_q[wr_ptr_q] <= data_i;
    end
  end

endmodule

`default_nettype wire

//--- dispatcher/vec_csr.sv
// Vector-length register, clamped to the maximum vector length on every write
`default_nettype none
`timescale 1ns/1ps

module vec_csr #(
  parameter int unsigned NrLanes      = 4,
  parameter int unsigned ElemsPerLane = 4
) (
  input  logic         clk_i,
  input  logic         rst_n_i,
  input  logic         vl_we_i,
  input  vec_pkg::vl_t vl_req_i,
  output vec_pkg::vl_t vl_o
);

  import vec_pkg::*;

  localparam int unsigned MaxVl = NrLanes * ElemsPerLane;

  vl_t vl_q;
  vl_t vl_clamped;

  assign vl_clamped = (vl_req_i > vl_t'(MaxVl)) ? vl_t'(MaxVl) : vl_req_i;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      vl_q <= '0;
    end else if (vl_we_i) begin
      vl_q <= vl_clamped;
    end
  end

  // Write-through, so the vsetvl response carries the new value in the same cycle
  assign vl_o = vl_we_i ? vl_clamped : vl_q;

endmodule

`default_nettype wire

//--- dispatcher/vec_dispatcher.sv
// Instruction dispatcher: runs vsetvl locally, hands vector ops to the sequencer, forms responses
`default_nettype none
`timescale 1ns/1ps

module vec_dispatcher (
  input  logic               clk_i,
  input  logic               rst_n_i,
  // Request FIFO
  input  vec_pkg::vec_req_t  req_i,
  input  logic               req_valid_i,
  output logic               req_ready_o,
  // Vector-length register
  input  vec_pkg::vl_t       vl_i,
  output logic               vl_we_o,
  output vec_pkg::vl_t       vl_req_o,
  // Sequencer
  output vec_pkg::seq_cmd_t  cmd_o,
  output logic               cmd_valid_o,
  input  logic               cmd_ready_i,
  input  logic               done_i,
  input  vec_pkg::elem_t     done_data_i,
  // Response FIFO
  output vec_pkg::vec_resp_t resp_o,
  output logic               resp_valid_o,
  input  logic               resp_ready_i
);

  import vec_pkg::*;

  typedef enum logic [1:0] {
    Idle,
    WaitSeq,
    HoldResp
  } state_e;

  state_e    state_q;
  state_e    state_d;
  // Op of the instruction in flight, then its finished response
  vec_resp_t resp_q;
  vec_resp_t resp_d;
  vec_resp_t done_resp;

  // Requested values beyond the vl range saturate, the CSR clamps them afterwards
  assign vl_req_o = (|req_i.scalar[ElemWidth-1:$bits(vl_t)]) ? '1 : req_i.scalar[$bits(vl_t)-1:0];
  assign cmd_o    = '{req: req_i, vl: vl_i};

  // Only an extraction returns data from the lanes
  assign done_resp.op   = resp_q.op;
  assign done_resp.data = (resp_q.op == VEXT_XV) ? done_data_i : '0;

  always_comb begin
    state_d      = state_q;
    resp_d       = resp_q;
    req_ready_o  = 1'b0;
    vl_we_o      = 1'b0;
    cmd_valid_o  = 1'b0;
    resp_valid_o = 1'b0;
    resp_o       = resp_q;

    case (state_q)
      Idle: begin
        if (req_valid_i) begin
          if (req_i.op == VSETVL) begin
            // Pop, write and answer together once the response FIFO has room
            if (resp_ready_i) begin
              req_ready_o  = 1'b1;
              vl_we_o      = 1'b1;
              resp_valid_o = 1'b1;
              resp_o       = '{op: VSETVL, data: elem_t'(vl_i)};
            end
          end else begin
            cmd_valid_o = 1'b1;
            if (cmd_ready_i) begin
              req_ready_o = 1'b1;
              resp_d.op   = req_i.op;
              state_d     = WaitSeq;
            end
          end
        end
      end
      WaitSeq: begin
        resp_o = done_resp;
        if (done_i) begin
          resp_valid_o = 1'b1;
          resp_d       = done_resp;
          state_d      = resp_ready_i ? Idle : HoldResp;
        end
      end
      HoldResp: begin
        resp_valid_o = 1'b1;
        if (resp_ready_i) state_d = Idle;
      end
      default: state_d = Idle;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q <= Idle;
    end else begin
      state_q <= state_d;
    end
  end

  always_ff @(posedge clk_i) begin
    resp_q <= resp_d;
  end

endmodule

`default_nettype wire

//--- sequencer/vec_sequencer.sv
// Sequencer that issues one instruction row by row to all lanes and collects extracted elements
`default_nettype none
`timescale 1ns/1ps

module vec_sequencer #(
  parameter int unsigned NrLanes      = 4,
  parameter int unsigned ElemsPerLane = 4
) (
  input  logic                            clk_i,
  input  logic                            rst_n_i,
  // Dispatcher
  input  vec_pkg::seq_cmd_t               cmd_i,
  input  logic                            cmd_valid_i,
  output logic                            cmd_ready_o,
  // Lanes
  output vec_pkg::lane_cmd_t              lane_cmd_o,
  output logic                            lane_cmd_valid_o,
  input  vec_pkg::elem_t    [NrLanes-1:0] rd_elem_i,
  // Completion
  output logic                            done_o,
  output vec_pkg::elem_t                  done_data_o
);

  import vec_pkg::*;

  localparam int unsigned MaxVl     = NrLanes * ElemsPerLane;
  localparam int unsigned RowWidth  = (ElemsPerLane > 1) ? $clog2(ElemsPerLane) : 1;
  localparam int unsigned LaneWidth = (NrLanes > 1) ? $clog2(NrLanes) : 1;

  typedef enum logic [1:0] {
    Idle,
    Issue,
    Finish
  } state_e;

  state_e               state_q;
  seq_cmd_t             cmd_q;
  logic [RowWidth-1:0]  row_q;
  logic [RowWidth-1:0]  last_row_q;
  logic [LaneWidth-1:0] ext_lane_q;
  logic                 ext_in_range_q;
  elem_t                data_q;
  logic                 accept;
  logic                 is_ext;
  vl_t                  nr_rows;
  logic [RowWidth-1:0]  ext_row;

  assign accept  = cmd_valid_i & cmd_ready_o;
  assign is_ext  = (cmd_i.req.op == VEXT_XV);
  // ceil(vl / NrLanes); vl never exceeds MaxVl, so this fits the row counter
  assign nr_rows = (cmd_i.vl + vl_t'(NrLanes - 1)) / vl_t'(NrLanes);
  assign ext_row = RowWidth'(cmd_i.req.scalar / NrLanes);

  assign cmd_ready_o      = (state_q == Idle);
  assign lane_cmd_valid_o = (state_q == Issue);
  assign done_o           = (state_q == Finish);
  assign done_data_o      = data_q;

  always_comb begin
    lane_cmd_o.op     = cmd_q.req.op;
    lane_cmd_o.vd     = cmd_q.req.vd;
    lane_cmd_o.vs1    = cmd_q.req.vs1;
    lane_cmd_o.vs2    = cmd_q.req.vs2;
    lane_cmd_o.scalar = cmd_q.req.scalar;
    lane_cmd_o.row    = vl_t'(row_q);
    lane_cmd_o.vl     = cmd_q.vl;
  end

  ////////////////////
  // Control
  ////////////////////

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q <= Idle;
    end else begin
      case (state_q)
        Idle: begin
          if (accept) begin
            // An empty vector op has no rows to issue
            state_q <= (!is_ext && cmd_i.vl == '0) ? Finish : Issue;
          end
        end
        Issue: begin
          if (row_q == last_row_q) state_q <= Finish;
        end
        default: state_q <= Idle;
      endcase
    end
  end

  ////////////////////
  // Datapath
  ////////////////////

  always_ff @(posedge clk_i) begin
    if (accept) begin
      cmd_q          <= cmd_i;
      row_q          <= is_ext ? ext_row : '0;
      last_row_q     <= is_ext ? ext_row : RowWidth'(nr_rows - vl_t'(1));
      ext_lane_q     <= LaneWidth'(cmd_i.req.scalar % NrLanes);
      ext_in_range_q <= (cmd_i.req.scalar < elem_t'(MaxVl));
    end else if (state_q == Issue) begin
      row_q <= row_q + 1'b1;
      // Extraction reads its lane in the single issued row
      if (cmd_q.req.op == VEXT_XV) begin
        data_q <= ext_in_range_q ? rd_elem_i[ext_lane_q] : '0;
      end
    end
  end

endmodule

`default_nettype wire

//--- lane/vec_lane.sv
// Vector lane holding its slice of the register file and the element ALU
`default_nettype none
`timescale 1ns/1ps

module vec_lane #(
  parameter int unsigned NrLanes      = 4,
  parameter int unsigned ElemsPerLane = 4,
  parameter int unsigned LaneId       = 0
) (
  input  logic               clk_i,
  input  logic               rst_n_i,
  // Broadcast from the sequencer
  input  vec_pkg::lane_cmd_t lane_cmd_i,
  input  logic               lane_cmd_valid_i,
  // vs2 element at the commanded row
  output vec_pkg::elem_t     rd_elem_o
);

  import vec_pkg::*;

  localparam int unsigned RowWidth = (ElemsPerLane > 1) ? $clog2(ElemsPerLane) : 1;

  // Element i sits in lane i mod NrLanes at row i / NrLanes
  elem_t               vrf_q [NrVRegs][ElemsPerLane];
  logic [RowWidth-1:0] row;
  vl_t                 elem_idx;
  elem_t               op_a;
  elem_t               op_b;
  elem_t               result;
  logic                is_arith;
  logic                we;

  assign row      = lane_cmd_i.row[RowWidth-1:0];
  assign elem_idx = lane_cmd_i.row * vl_t'(NrLanes) + vl_t'(LaneId);

  ////////////////////
  // Operand read
  ////////////////////

  assign op_a      = vrf_q[lane_cmd_i.vs2][row];
  assign op_b      = vrf_q[lane_cmd_i.vs1][row];
  assign rd_elem_o = op_a;

  ////////////////////
  // ALU
  ////////////////////

  always_comb begin
    is_arith = 1'b1;
    case (lane_cmd_i.op)
      VADD:    result = op_a + op_b;
      VSUB:    result = op_a - op_b;
      VAND:    result = op_a & op_b;
      VOR:     result = op_a | op_b;
      VXOR:    result = op_a ^ op_b;
      VMV_VX:  result = lane_cmd_i.scalar;
      default: begin
        // vsetvl never reaches here, extraction only reads
        is_arith = 1'b0;
        result   = '0;
      end
    endcase
  end

  ////////////////////
  // Write back
  ////////////////////

  // Tail elements at or past vl keep their old value; no writes while in reset
  assign we = rst_n_i & lane_cmd_valid_i & is_arith & (elem_idx < lane_cmd_i.vl);

  always_ff @(posedge clk_i) begin
    if (we) begin
      vrf_q[lane_cmd_i.vd][row] <= result;
    end
  end

endmodule

`default_nettype wire

//--- hdl/vec_top.sv
// Vector coprocessor top level with request and response ports towards the core
`default_nettype none
`timescale 1ns/1ps

module vec_top #(
  parameter int unsigned NrLanes      = 4,
  parameter int unsigned ElemsPerLane = 4
) (
  input  logic               clk_i,
  input  logic               rst_n_i,
  // Request port
  input  vec_pkg::vec_req_t  req_i,
  input  logic               req_valid_i,
  output logic               req_ready_o,
  // Response port
  output vec_pkg::vec_resp_t resp_o,
  output logic               resp_valid_o,
  input  logic               resp_ready_i
);

  import vec_pkg::*;

  vec_req_t                fifo_req;
  logic                    fifo_req_valid;
  logic                    fifo_req_ready;
  vec_resp_t               disp_resp;
  logic                    disp_resp_valid;
  logic                    disp_resp_ready;
  vl_t                     vl;
  logic                    vl_we;
  vl_t                     vl_req;
  seq_cmd_t                cmd;
  logic                    cmd_valid;
  logic                    cmd_ready;
  logic                    done;
  elem_t                   done_data;
  lane_cmd_t               lane_cmd;
  logic                    lane_cmd_valid;
  elem_t     [NrLanes-1:0] rd_elem;

  ////////////////////
  // Buffers
  ////////////////////

  vec_skid_fifo #(
    .payload_t(vec_req_t)
  ) i_req_fifo (
    .clk_i  (clk_i         ),
    .rst_n_i(rst_n_i       ),
    .data_i (req_i         ),
    .valid_i(req_valid_i   ),
    .ready_o(req_ready_o   ),
    .data_o (fifo_req      ),
    .valid_o(fifo_req_valid),
    .ready_i(fifo_req_ready)
  );

  vec_skid_fifo #(
    .payload_t(vec_resp_t)
  ) i_resp_fifo (
    .clk_i  (clk_i          ),
    .rst_n_i(rst_n_i        ),
    .data_i (disp_resp      ),
    .valid_i(disp_resp_valid),
    .ready_o(disp_resp_ready),
    .data_o (resp_o         ),
    .valid_o(resp_valid_o   ),
    .ready_i(resp_ready_i   )
  );

  ////////////////////
  // Dispatch
  ////////////////////

  vec_csr #(
    .NrLanes     (NrLanes     ),
    .ElemsPerLane(ElemsPerLane)
  ) i_csr (
    .clk_i   (clk_i  ),
    .rst_n_i (rst_n_i),
    .vl_we_i (vl_we  ),
    .vl_req_i(vl_req ),
    .vl_o    (vl     )
  );

  vec_dispatcher i_dispatcher (
    .clk_i       (clk_i          ),
    .rst_n_i     (rst_n_i        ),
    .req_i       (fifo_req       ),
    .req_valid_i (fifo_req_valid ),
    .req_ready_o (fifo_req_ready ),
    .vl_i        (vl             ),
    .vl_we_o     (vl_we          ),
    .vl_req_o    (vl_req         ),
    .cmd_o       (cmd            ),
    .cmd_valid_o (cmd_valid      ),
    .cmd_ready_i (cmd_ready      ),
    .done_i      (done           ),
    .done_data_i (done_data      ),
    .resp_o      (disp_resp      ),
    .resp_valid_o(disp_resp_valid),
    .resp_ready_i(disp_resp_ready)
  );

  vec_sequencer #(
    .NrLanes     (NrLanes     ),
    .ElemsPerLane(ElemsPerLane)
  ) i_sequencer (
    .clk_i           (clk_i         ),
    .rst_n_i         (rst_n_i       ),
    .cmd_i           (cmd           ),
    .cmd_valid_i     (cmd_valid     ),
    .cmd_ready_o     (cmd_ready     ),
    .lane_cmd_o      (lane_cmd      ),
    .lane_cmd_valid_o(lane_cmd_valid),
    .rd_elem_i       (rd_elem       ),
    .done_o          (done          ),
    .done_data_o     (done_data     )
  );

  ////////////////////
  // Lanes
  ////////////////////

  for (genvar lane = 0; lane < NrLanes; lane++) begin : gen_lanes
    vec_lane #(
      .NrLanes     (NrLanes     ),
      .ElemsPerLane(ElemsPerLane),
      .LaneId      (lane        )
    ) i_lane (
      .clk_i           (clk_i         ),
      .rst_n_i         (rst_n_i       ),
      .lane_cmd_i      (lane_cmd      ),
      .lane_cmd_valid_i(lane_cmd_valid),
      .rd_elem_o       (rd_elem[lane] )
    );
  end : gen_lanes

endmodule

`default_nettype wire

//--- tests/vec_checker.sv
// Vector coprocessor checker with a shadow register file that predicts and compares responses
`default_nettype none
`timescale 1ns/1ps

module vec_checker #(
  parameter int unsigned NrLanes      = 4,
  parameter int unsigned ElemsPerLane = 4
) (
  input logic               clk_i,
  input logic               rst_n_i,
  // Request port of the DUT
  input vec_pkg::vec_req_t  req_i,
  input logic               req_valid_i,
  input logic               req_ready_i,
  // Response port of the DUT
  input vec_pkg::vec_resp_t resp_i,
  input logic               resp_valid_i,
  input logic               resp_ready_i
);

  import vec_pkg::*;

  localparam int unsigned MaxVl = NrLanes * ElemsPerLane;

  // One predicted response; learn marks an extraction of a never-written element
  typedef struct packed {
    vec_op_e   op;
    elem_t     data;
    logic      known;
    logic      learn;
    vreg_idx_t vreg;
    vl_t       idx;
  } expect_t;

  // Flat element view, element i of register r
  elem_t       shadow_val   [NrVRegs][MaxVl];
  logic        shadow_known [NrVRegs][MaxVl];
  int unsigned model_vl;
  expect_t     expect_q [$];

  int error_count;
  int check_count;
  int outstanding;

  initial begin
    model_vl = 0;
    for (int r = 0; r < NrVRegs; r++) begin
      for (int i = 0; i < MaxVl; i++) begin
        shadow_known[r][i] = 1'b0;
      end
    end
  end

  ////////////////////
  // Reference model
  ////////////////////

  function automatic expect_t model_request(input vec_req_t r);
    expect_t e;
    elem_t   a;
    elem_t   b;
    elem_t   res;
    logic    kn;
    int      i;
    e = '{op: r.op, data: '0, known: 1'b1, learn: 1'b0, vreg: r.vs2, idx: '0};
    case (r.op)
      VSETVL: begin
        model_vl = (r.scalar > MaxVl) ? MaxVl : r.scalar;
        e.data   = elem_t'(model_vl);
      end
      VEXT_XV: begin
        // Indices past the register give 0
        if (r.scalar < MaxVl) begin
          e.idx   = vl_t'(r.scalar);
          e.data  = shadow_val[r.vs2][r.scalar];
          e.known = shadow_known[r.vs2][r.scalar];
          e.learn = !e.known;
        end
      end
      default: begin
        for (i = 0; i < int'(model_vl); i++) begin
          a  = shadow_val[r.vs2][i];
          b  = shadow_val[r.vs1][i];
          kn = shadow_known[r.vs2][i] & shadow_known[r.vs1][i];
          case (r.op)
            VADD:    res = a + b;
            VSUB:    res = a - b;
            VAND:    res = a & b;
            VOR:     res = a | b;
            VXOR:    res = a ^ b;
            default: begin
              res = r.scalar;
              kn  = 1'b1;
            end
          endcase
          shadow_val[r.vd][i]   = res;
          shadow_known[r.vd][i] = kn;
        end
      end
    endcase
    return e;
  endfunction

  ////////////////////
  // Compare
  ////////////////////

  always @(posedge clk_i) begin : compare
    expect_t e;
    if (!rst_n_i) begin
      model_vl = 0;
      expect_q.delete();
    end else begin
      if (req_valid_i && req_ready_i) begin
        expect_q.push_back(model_request(req_i));
      end
      if (resp_valid_i && resp_ready_i) begin
        if (expect_q.size() == 0) begin
          error_count++;
          $display("At %0t a response arrived with no request outstanding", $time);
        end else begin
          e = expect_q.pop_front();
          check_count++;
          if (resp_i.op !== e.op) begin
            error_count++;
            $display("CHECK FAILED at %0t: resp_o.op expected %0d, got %0d",
                     $time, e.op, resp_i.op);
          end else if (e.known && (resp_i.data !== e.data)) begin
            error_count++;
            $display("CHECK FAILED at %0t: resp_o.data expected %h, got %h",
                     $time, e.data, resp_i.data);
          end else if (e.learn && !shadow_known[e.vreg][e.idx]) begin
            // First look at an unwritten element fixes its value from now on
            shadow_val[e.vreg][e.idx]   = resp_i.data;
            shadow_known[e.vreg][e.idx] = 1'b1;
          end
        end
      end
    end
    outstanding = expect_q.size();
  end

endmodule

`default_nettype wire

//--- tests/tb_vec_top.sv
// Vector coprocessor testbench with reset, request stimulus and throttled response draining
`default_nettype none
`timescale 1ns/1ps

module tb_vec_top;

  import vec_pkg::*;

  localparam int unsigned NrLanes      = 4;
  localparam int unsigned ElemsPerLane = 4;
  localparam int unsigned MaxVl        = NrLanes * ElemsPerLane;
  // Longest any single wait may take, in cycles
  localparam int unsigned WaitLimit    = 2000;

  logic      clk_i;
  logic      rst_n_i;
  vec_req_t  req_i;
  logic      req_valid_i;
  logic      req_ready_o;
  vec_resp_t resp_o;
  logic      resp_valid_o;
  logic      resp_ready_i;

  logic      throttle;
  logic      timed_out;
  int        test_count;
  int        sent_count;
  int        errs_before;

  vec_top uut (
    .clk_i       (clk_i       ),
    .rst_n_i     (rst_n_i     ),
    .req_i       (req_i       ),
    .req_valid_i (req_valid_i ),
    .req_ready_o (req_ready_o ),
    .resp_o      (resp_o      ),
    .resp_valid_o(resp_valid_o),
    .resp_ready_i(resp_ready_i)
  );

  vec_checker #(
    .NrLanes     (NrLanes     ),
    .ElemsPerLane(ElemsPerLane)
  ) u_checker (
    .clk_i       (clk_i       ),
    .rst_n_i     (rst_n_i     ),
    .req_i       (req_i       ),
    .req_valid_i (req_valid_i ),
    .req_ready_i (req_ready_o ),
    .resp_i      (resp_o      ),
    .resp_valid_i(resp_valid_o),
    .resp_ready_i(resp_ready_i)
  );

  initial begin
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i;
  end

  ////////////////////
  // Helpers
  ////////////////////

  // Response back-pressure, random only while throttling is on
  task automatic throttle_responses();
    forever begin
      @(posedge clk_i);
      #1;
      resp_ready_i = throttle ? 1'($urandom_range(1, 0)) : 1'b1;
    end
  endtask

  function automatic vec_req_t make_req(input vec_op_e op, input int unsigned vd,
                                        input int unsigned vs1, input int unsigned vs2,
                                        input elem_t scalar);
    vec_req_t r;
    r.op     = op;
    r.vd     = vreg_idx_t'(vd);
    r.vs1    = vreg_idx_t'(vs1);
    r.vs2    = vreg_idx_t'(vs2);
    r.scalar = scalar;
    return r;
  endfunction

  function automatic vec_req_t random_alu_req();
    vec_op_e op;
    op = vec_op_e'(3'($urandom_range(5, 1)));
    return make_req(op, $urandom_range(31, 0), $urandom_range(31, 0),
                    $urandom_range(31, 0), '0);
  endfunction

  function automatic vec_req_t random_any_req();
    case ($urandom_range(7, 0))
      0:       return make_req(VSETVL, 0, 0, 0, $urandom_range(20, 0));
      6:       return make_req(VMV_VX, $urandom_range(31, 0), 0, 0, $urandom);
      7:       return make_req(VEXT_XV, 0, 0, $urandom_range(31, 0), $urandom_range(19, 0));
      default: return random_alu_req();
    endcase
  endfunction

  // Hold the request until the port takes it
  task automatic send_request(input vec_req_t r);
    int unsigned waited;
    logic        accepted;
    if (!timed_out) begin
      req_i       = r;
      req_valid_i = 1'b1;
      waited      = 0;
      do begin
        @(posedge clk_i);
        accepted = req_ready_o;
        waited++;
      end while (!accepted && waited < WaitLimit);
      #1;
      req_valid_i = 1'b0;
      if (accepted) begin
        sent_count++;
      end else begin
        $display("Timed out waiting for the request port to accept an instruction");
        timed_out = 1'b1;
      end
    end
  endtask

  task automatic drain_responses();
    int unsigned waited;
    waited = 0;
    while (!timed_out && u_checker.outstanding != 0 && waited < WaitLimit) begin
      @(posedge clk_i);
      #1;
      waited++;
    end
    if (!timed_out && u_checker.outstanding != 0) begin
      $display("Timed out with %0d responses still missing", u_checker.outstanding);
      timed_out = 1'b1;
    end
  endtask

  task automatic issue_and_wait(input vec_req_t r);
    send_request(r);
    drain_responses();
  endtask

  task automatic extract_all(input int unsigned vreg);
    for (int i = 0; i < MaxVl; i++) begin
      send_request(make_req(VEXT_XV, 0, 0, vreg, i));
    end
  endtask

  task automatic close_test(input string name);
    int errs;
    drain_responses();
    test_count++;
    errs = u_checker.error_count - errs_before;
    $display("Test %0d %-20s %s, %0d errors", test_count, name,
             (errs == 0 && !timed_out) ? "ok" : "failed", errs);
    errs_before = u_checker.error_count;
  endtask

  ////////////////////
  // Stimulus
  ////////////////////

  initial begin
    elem_t    vl_values [7];
    vec_req_t r;
    logic     count_bad;
    rst_n_i      = 1'b0;
    req_i        = '0;
    req_valid_i  = 1'b0;
    resp_ready_i = 1'b1;
    throttle     = 1'b0;
    timed_out    = 1'b0;
    test_count   = 0;
    sent_count   = 0;
    errs_before  = 0;
    count_bad    = 1'b0;
    vl_values    = '{32'd0, 32'd5, 32'd16, 32'd17, 32'd40, 32'h0001_0003, 32'hffff_ffff};
    void'($urandom(32'h9f6a));
    // Forked after seeding so the back-pressure draws from the same seed
    fork
      throttle_responses();
    join_none
    repeat (16) @(posedge clk_i);
    #1;
    rst_n_i = 1'b1;

    // vl is 0 out of reset, so vector ops must not touch v9
    issue_and_wait(make_req(VEXT_XV, 0, 0, 9, 2));
    issue_and_wait(make_req(VADD, 9, 10, 11, 0));
    issue_and_wait(make_req(VMV_VX, 9, 0, 0, 32'h1234_5678));
    issue_and_wait(make_req(VSETVL, 0, 0, 0, 16));
    issue_and_wait(make_req(VEXT_XV, 0, 0, 9, 2));
    close_test("reset vl zero");

    for (int i = 0; i < 7; i++) begin
      send_request(make_req(VSETVL, 0, 0, 0, vl_values[i]));
    end
    close_test("vsetvl clamping");

    send_request(make_req(VSETVL, 0, 0, 0, 16));
    for (int v = 1; v <= 4; v++) begin
      send_request(make_req(VMV_VX, v, 0, 0, $urandom));
    end
    for (int v = 1; v <= 4; v++) begin
      extract_all(v);
    end
    send_request(make_req(VEXT_XV, 0, 0, 1, 16));
    send_request(make_req(VEXT_XV, 0, 0, 2, 32'h8000_0000));
    close_test("broadcast extract");

    // Fill every register, then mix with short vl so vectors differ per element
    for (int v = 0; v < NrVRegs; v++) begin
      send_request(make_req(VMV_VX, v, 0, 0, $urandom));
    end
    for (int i = 0; i < 16; i++) begin
      send_request(make_req(VSETVL, 0, 0, 0, $urandom_range(16, 1)));
      send_request(random_alu_req());
    end
    send_request(make_req(VSETVL, 0, 0, 0, 16));
    for (int i = 0; i < 24; i++) begin
      r = random_alu_req();
      send_request(r);
      extract_all(r.vd);
    end
    close_test("random alu ops");

    send_request(make_req(VSETVL, 0, 0, 0, 16));
    send_request(make_req(VMV_VX, 20, 0, 0, $urandom));
    send_request(make_req(VMV_VX, 21, 0, 0, $urandom));
    send_request(make_req(VMV_VX, 22, 0, 0, $urandom));
    send_request(make_req(VSETVL, 0, 0, 0, 7));
    send_request(make_req(VADD, 20, 22, 21, 0));
    send_request(make_req(VSETVL, 0, 0, 0, 10));
    send_request(make_req(VXOR, 21, 22, 20, 0));
    send_request(make_req(VSETVL, 0, 0, 0, 16));
    extract_all(20);
    extract_all(21);
    close_test("tail undisturbed");

    throttle = 1'b1;
    for (int i = 0; i < 300; i++) begin
      send_request(random_any_req());
    end
    drain_responses();
    throttle = 1'b0;
    close_test("throttled stream");

    if (!timed_out && u_checker.check_count != sent_count) begin
      $display("Received %0d responses for %0d requests", u_checker.check_count, sent_count);
      count_bad = 1'b1;
    end
    $display("Tests %0d, responses checked %0d, errors %0d", test_count,
             u_checker.check_count, u_checker.error_count);
    if (u_checker.error_count == 0 && !timed_out && !count_bad) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- compile.f
common/vec_pkg.sv
hdl/vec_skid_fifo.sv
dispatcher/vec_csr.sv
dispatcher/vec_dispatcher.sv
sequencer/vec_sequencer.sv
lane/vec_lane.sv
hdl/vec_top.sv
tests/vec_checker.sv
tests/tb_vec_top.sv
